// File: Makefile
# Verilator build and run for the data cache TQ front end

VERILATOR  ?= verilator
TOP        ?= tb_dcache_tq
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
FAIL_MSG   ?= Testbench failed
PASS_MSG   ?= Testbench passed

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "No result line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
verilog/dcache_tq_pkg.sv
verilog/core_req_align.sv
verilog/miss_reissue_ctrl.sv
verilog/load_rsp_format.sv
verilog/dcache_tq_top.sv
test/tq_checker.sv
test/tb_dcache_tq.sv

// File: test/tb_dcache_tq.sv
/*
 * Testbench top for the data cache TQ front end
 * Clock, reset, LCG stimulus and pipe stand-in
 * Watchdog, DUT instance and checker
 */
`timescale 1ns/100ps
`default_nettype none

module tb_dcache_tq
    import dcache_tq_pkg::*;
();

localparam int         CLK_PERIOD   = 40;
localparam int         RST_CYCLES   = 10;
localparam int         N_WR         = 200;
localparam int         N_RD         = 200;
localparam int         N_MISS       = 24;
localparam int         MISS_CYCLES  = 24;     // Worst case of one miss sequence
localparam int         N_RSP        = 300;
localparam int         TOTAL_CYCLES = 3*RST_CYCLES + N_WR + N_RD + N_MISS*MISS_CYCLES +
                                      N_RSP + 60;
localparam int         WATCHDOG_NS  = TOTAL_CYCLES*CLK_PERIOD + 100*CLK_PERIOD;
localparam logic [3:0] TEST_END     = 4'd15;

logic          clk;
logic          rst;
t_req          pre_req;
t_early_lu_rsp early_rsp;     // Pipe stand-in, Q2
t_lu_rsp       lu_rsp;        // Pipe stand-in, Q3
logic          ready;
t_rd_rsp       core_rsp;
t_lu_req       lu_req;
logic [3:0]    test_id;
logic [31:0]   lcg_state;
int            chk_errors;
int            tb_errors;     // Failures seen by the stimulus itself

// ========================================
// DUT and checker
// ========================================
dcache_tq_top uut (
    .clk                  (clk),
    .rst                  (rst),
    .pre_core2cache_req   (pre_req),
    .ready                (ready),
    .cache2core_rsp       (core_rsp),
    .pipe_lu_req_q1       (lu_req),
    .pipe_early_lu_rsp_q2 (early_rsp),
    .pipe_lu_rsp_q3       (lu_rsp)
);

tq_checker u_checker (
    .clk                  (clk),
    .rst                  (rst),
    .test_id              (test_id),
    .pre_core2cache_req   (pre_req),
    .pipe_early_lu_rsp_q2 (early_rsp),
    .pipe_lu_rsp_q3       (lu_rsp),
    .ready                (ready),
    .pipe_lu_req_q1       (lu_req),
    .cache2core_rsp       (core_rsp),
    .error_count          (chk_errors)
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
end

initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, stimulus never finished", WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
end

// ========================================
// Random stimulus
// ========================================
// LCG step, high bits folded down since the low bits repeat quickly
function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 15);
endfunction

function automatic t_req rand_req(input t_opcode op);
    t_req        r;
    logic [31:0] x;
    x             = next_rand();
    r.valid       = x[0] | x[1];              // Roughly three of four cycles busy
    r.opcode      = op;
    r.address     = x[31:12];
    r.data        = next_rand();
    r.byte_en     = x[5:2] | 4'b0001;         // Lane 0 keeps a store nonzero
    r.sign_extend = x[6];
    r.reg_id      = x[11:7];
    return r;
endfunction

function automatic t_lu_rsp rand_rsp();
    t_lu_rsp     p;
    logic [31:0] x;
    logic [31:0] y;
    x               = next_rand();
    y               = next_rand();
    p.lu_op         = t_lu_op'(x[1:0]);
    p.lu_result     = t_lu_result'(x[3:2]);
    p.valid         = (x[4] | x[5]) && (x[1:0] != 2'd0);   // Never a live NO_LU
    p.rd_indication = x[6];
    p.byte_en       = x[10:7];
    p.sign_extend   = x[11];
    p.address       = x[31:12];
    p.reg_id        = y[4:0];
    p.cl_data       = {next_rand(), next_rand(), next_rand(), next_rand()};
    return p;
endfunction

function automatic t_early_lu_rsp early_ind(input logic miss, input logic fill,
                                            input t_cl_address cl);
    t_early_lu_rsp e;
    e.rd_miss    = miss;
    e.fill_done  = fill;
    e.cl_address = cl;
    return e;
endfunction

// ========================================
// Test sequences
// ========================================
task automatic apply_reset();
    @(posedge clk);
    rst       <= 1'b1;
    pre_req   <= '0;
    early_rsp <= '0;
    lu_rsp    <= '0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
endtask

task automatic start_test(input logic [3:0] id);
    @(posedge clk);
    pre_req   <= '0;
    early_rsp <= '0;
    lu_rsp    <= '0;
    test_id   <= id;
endtask

task automatic run_core_reqs(input t_opcode op, input int n);
    for (int i = 0; i < n; i++) begin
        @(posedge clk);
        pre_req <= rand_req(op);
    end
endtask

// Read that misses, a fill of another line, then the matching fill
task automatic run_miss();
    t_req        r;
    t_cl_address cl;
    int          gap;
    int          waited;
    run_core_reqs(RD_OP, 2);
    r       = rand_req(RD_OP);
    r.valid = 1'b1;
    cl      = r.address[MSB_CL_ADDR:LSB_CL_ADDR];
    gap     = 2 + int'(next_rand() % 32'd9);
    @(posedge clk);
    pre_req   <= r;
    early_rsp <= early_ind(1'b1, 1'b0, cl);
    @(posedge clk);
    pre_req   <= '0;
    early_rsp <= early_ind(1'b0, 1'b1, cl ^ 16'h0001);   // Wrong line, stall holds
    for (int k = 2; k < gap; k++) begin
        @(posedge clk);
        early_rsp <= '0;
    end
    @(posedge clk);
    early_rsp <= early_ind(1'b0, 1'b1, cl);
    @(posedge clk);
    early_rsp <= '0;                  // Reissue cycle
    waited = 0;
    @(negedge clk);
    while (!ready && waited < 4) begin
        @(negedge clk);
        waited++;
    end
    if (!ready) begin
        $display("ready did not return after the matching fill of line %h", cl);
        tb_errors++;
    end
endtask

task automatic run_responses(input int n);
    for (int i = 0; i < n; i++) begin
        @(posedge clk);
        lu_rsp <= rand_rsp();
    end
endtask

// Reset while a miss is outstanding, then idle
task automatic run_reset_check();
    t_req r;
    r       = rand_req(RD_OP);
    r.valid = 1'b1;
    @(posedge clk);
    pre_req   <= r;
    early_rsp <= early_ind(1'b1, 1'b0, r.address[MSB_CL_ADDR:LSB_CL_ADDR]);
    apply_reset();
    repeat (12) @(posedge clk);
endtask

// ========================================
// Main sequence
// ========================================
initial begin
    rst       = 1'b1;
    pre_req   = '0;
    early_rsp = '0;
    lu_rsp    = '0;
    test_id   = 4'd0;
    tb_errors = 0;
    lcg_state = 32'h425a_b36b;
    apply_reset();

    start_test(4'd1);
    run_core_reqs(WR_OP, N_WR);
    start_test(4'd2);
    run_core_reqs(RD_OP, N_RD);
    start_test(4'd3);
    for (int i = 0; i < N_MISS; i++) begin
        run_miss();
    end
    start_test(4'd4);
    run_responses(N_RSP);
    start_test(4'd5);
    run_reset_check();

    start_test(TEST_END);
    repeat (3) @(posedge clk);
    if (chk_errors + tb_errors == 0) begin
        $display("Testbench passed");
    end else begin
        $display("Testbench failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: test/tq_checker.sv
/*
 * Checker for the data cache TQ front end
 * Reference model of align, miss stall, reissue and load format
 * Per cycle comparisons, per test result lines and closing counts
 */
`timescale 1ns/100ps
`default_nettype none

module tq_checker
    import dcache_tq_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [3:0]        test_id,              // Current test, 15 ends the run
    input  var t_req          pre_core2cache_req,
    input  var t_early_lu_rsp pipe_early_lu_rsp_q2,
    input  var t_lu_rsp       pipe_lu_rsp_q3,
    input  logic              ready,
    input  var t_lu_req       pipe_lu_req_q1,
    input  var t_rd_rsp       cache2core_rsp,
    output int                error_count
);

localparam logic [3:0] TEST_END = 4'd15;

// Model state
t_req        held_req;      // Request waiting for its line
t_cl_address held_cl;
logic        m_stall;
logic        m_filled;      // Matching fill seen, reissue next cycle
logic        fill_hit;

// Expected values of one cycle
t_req        src_req;
t_lu_req     exp_lu;
t_rd_rsp     exp_rsp;
logic        exp_ready;

logic [3:0]  cur_test;
int          test_checks;
int          test_errors;
int          total_checks;
int          tests_run;

initial begin
    held_req     = '0;
    held_cl      = '0;
    m_stall      = 1'b0;
    m_filled     = 1'b0;
    cur_test     = 4'd0;
    test_checks  = 0;
    test_errors  = 0;
    total_checks = 0;
    tests_run    = 0;
    error_count  = 0;
end

// ========================================
// Reference functions
// ========================================
// Store bytes move up by the byte offset, bytes pushed past lane 3 are lost
function automatic t_req align_req(input t_req r);
    t_req a;
    int   off;
    a   = r;
    off = int'(r.address[MSB_BYTE_OFFSET:LSB_BYTE_OFFSET]);
    if (r.opcode == WR_OP) begin
        a.data    = '0;
        a.byte_en = '0;
        for (int i = off; i < BYTE_EN_W; i++) begin
            a.data[BYTE_W*i +: BYTE_W] = r.data[BYTE_W*(i-off) +: BYTE_W];
            a.byte_en[i]               = r.byte_en[i-off];
        end
    end
    return a;
endfunction

function automatic t_lu_req build_lookup(input t_req r, input logic rd_miss);
    t_lu_req l;
    l               = '0;
    l.valid         = r.valid && !rd_miss;   // Miss kills the Q1 slot
    l.lu_op         = (r.opcode == WR_OP) ? WR_LU : RD_LU;
    l.address       = r.address;
    l.data          = r.data;
    l.byte_en       = r.byte_en;
    l.sign_extend   = r.sign_extend;
    l.reg_id        = r.reg_id;
    l.rd_indication = (r.opcode == RD_OP);
    l.wr_indication = (r.opcode == WR_OP);
    return l;
endfunction

function automatic t_rd_rsp format_rsp(input t_lu_rsp p);
    t_rd_rsp r;
    t_word   w;
    int      wo;
    int      off;
    logic    sgn;
    r       = '0;
    wo      = int'(p.address[MSB_WORD_OFFSET:LSB_WORD_OFFSET]);
    off     = int'(p.address[MSB_BYTE_OFFSET:LSB_BYTE_OFFSET]);
    w       = t_word'(p.cl_data >> (WORD_W * wo));
    r.valid = p.valid && (((p.lu_op == RD_LU) && (p.lu_result == HIT)) ||
                          ((p.lu_op == FILL_LU) && p.rd_indication));
    r.address = p.address;
    r.reg_id  = p.reg_id;
    sgn       = 1'b0;
    for (int i = 0; i < BYTE_EN_W; i++) begin
        if (p.byte_en[i]) begin
            if (i + off < BYTE_EN_W) begin
                r.data[BYTE_W*i +: BYTE_W] = w[BYTE_W*(i+off) +: BYTE_W];
            end
        end else if (p.sign_extend) begin
            r.data[BYTE_W*i +: BYTE_W] = {BYTE_W{sgn}};  // Sign of the byte below
        end
        sgn = r.data[BYTE_W*i + BYTE_W - 1];
    end
    return r;
endfunction

function automatic string test_name(input logic [3:0] id);
    case (id)
        4'd1:    return "aligned writes";
        4'd2:    return "plain reads";
        4'd3:    return "read miss and reissue";
        4'd4:    return "load responses";
        4'd5:    return "reset state";
        default: return "unnamed";
    endcase
endfunction

// ========================================
// Compare and report
// ========================================
task automatic check_field(input string name, input logic [63:0] exp, input logic [63:0] got);
    test_checks++;
    total_checks++;
    if (exp !== got) begin
        test_errors++;
        error_count++;
        $display("ERROR %s expected %h got %h at %0t ns", name, exp, got, $time);
    end
endtask

task automatic compare_outputs();
    check_field("ready", 64'(exp_ready), 64'(ready));
    check_field("pipe_lu_req_q1.valid", 64'(exp_lu.valid), 64'(pipe_lu_req_q1.valid));
    if (exp_lu.valid) begin         // Fields only matter on a live lookup
        check_field("pipe_lu_req_q1.lu_op", 64'(exp_lu.lu_op), 64'(pipe_lu_req_q1.lu_op));
        check_field("pipe_lu_req_q1.address", 64'(exp_lu.address),
                    64'(pipe_lu_req_q1.address));
        check_field("pipe_lu_req_q1.data", 64'(exp_lu.data), 64'(pipe_lu_req_q1.data));
        check_field("pipe_lu_req_q1.byte_en", 64'(exp_lu.byte_en),
                    64'(pipe_lu_req_q1.byte_en));
        check_field("pipe_lu_req_q1.sign_extend", 64'(exp_lu.sign_extend),
                    64'(pipe_lu_req_q1.sign_extend));
        check_field("pipe_lu_req_q1.reg_id", 64'(exp_lu.reg_id), 64'(pipe_lu_req_q1.reg_id));
        check_field("pipe_lu_req_q1.rd_indication", 64'(exp_lu.rd_indication),
                    64'(pipe_lu_req_q1.rd_indication));
        check_field("pipe_lu_req_q1.wr_indication", 64'(exp_lu.wr_indication),
                    64'(pipe_lu_req_q1.wr_indication));
    end
    check_field("cache2core_rsp.valid", 64'(exp_rsp.valid), 64'(cache2core_rsp.valid));
    if (exp_rsp.valid) begin
        check_field("cache2core_rsp.data", 64'(exp_rsp.data), 64'(cache2core_rsp.data));
        check_field("cache2core_rsp.address", 64'(exp_rsp.address),
                    64'(cache2core_rsp.address));
        check_field("cache2core_rsp.reg_id", 64'(exp_rsp.reg_id), 64'(cache2core_rsp.reg_id));
    end
endtask

task automatic report_test();
    tests_run++;
    if (test_errors == 0) begin
        $display("test %0d %s: PASS, %0d checks", cur_test, test_name(cur_test), test_checks);
    end else begin
        $display("test %0d %s: FAIL, %0d of %0d checks wrong",
                 cur_test, test_name(cur_test), test_errors, test_checks);
    end
endtask

// ========================================
// Cycle model
// ========================================
// Inputs move on the rising edge, so the falling edge sees them settled
always @(negedge clk) begin
    if (test_id != cur_test) begin
        if (cur_test != 4'd0) begin
            report_test();
        end
        if (test_id == TEST_END) begin
            $display("tests %0d, checks %0d, errors %0d", tests_run, total_checks, error_count);
        end
        cur_test    = test_id;
        test_checks = 0;
        test_errors = 0;
    end

    src_req   = m_filled ? held_req : align_req(pre_core2cache_req);
    exp_lu    = build_lookup(src_req, pipe_early_lu_rsp_q2.rd_miss);
    exp_ready = !(m_stall || pipe_early_lu_rsp_q2.rd_miss);
    exp_rsp   = format_rsp(pipe_lu_rsp_q3);

    if (!rst) begin
        compare_outputs();
    end

    // Fill must match the line stored by the earlier miss
    fill_hit = m_stall && !m_filled && pipe_early_lu_rsp_q2.fill_done &&
               (pipe_early_lu_rsp_q2.cl_address == held_cl);
    if (pipe_early_lu_rsp_q2.rd_miss) begin
        held_req = src_req;
        held_cl  = pipe_early_lu_rsp_q2.cl_address;
    end
    if (rst) begin
        m_stall  = 1'b0;
        m_filled = 1'b0;
    end else begin
        m_stall  = pipe_early_lu_rsp_q2.rd_miss || (m_stall && !m_filled);
        m_filled = !m_filled && fill_hit;
    end
end

endmodule

`default_nettype wire

// File: verilog/core_req_align.sv
/*
 * Core request aligner
 * Shifts store data and byte enables to the byte offset
 */
`timescale 1ns/100ps
`default_nettype none

module core_req_align
    import dcache_tq_pkg::*;
(
    input  var t_req pre_core2cache_req,   // Raw request from the core
    output t_req     aligned_req           // Request placed on the word lanes
);

// ========================================
// Offset decode
// ========================================
logic [MSB_BYTE_OFFSET:LSB_BYTE_OFFSET] byte_offset;
logic [$clog2(WORD_W)-1:0]              bit_shift;

assign byte_offset = pre_core2cache_req.address[MSB_BYTE_OFFSET:LSB_BYTE_OFFSET];
assign bit_shift   = {byte_offset, 3'b000};   // 8 bits per byte of offset

// ========================================
// Store alignment
// ========================================
// Core gives the store data right justified, the line wants it in place
always_comb begin
    aligned_req = pre_core2cache_req;  // Reads pass through as is
    if (pre_core2cache_req.opcode == WR_OP) begin
        aligned_req.data    = pre_core2cache_req.data << bit_shift;      // Zero fill below
        aligned_req.byte_en = pre_core2cache_req.byte_en << byte_offset; // One lane per byte
    end
end

// Store must not enable bytes that fall past the end of the word
a_wr_byte_en_in_word: assert final (
    !(pre_core2cache_req.valid && (pre_core2cache_req.opcode == WR_OP)) ||
    (aligned_req.byte_en != '0)
) else $error("core_req_align: write byte_en shifted out, addr=%h be=%h",
              pre_core2cache_req.address, pre_core2cache_req.byte_en);

endmodule

`default_nettype wire

// File: verilog/dcache_tq_pkg.sv
/*
 * Data cache TQ front end shared definitions
 * Widths and address field positions
 * Opcode and lookup enums
 * Core request, pipe lookup and response structs
 */
`default_nettype none

package dcache_tq_pkg;

// ========================================
// Widths and address fields
// ========================================
localparam int ADDR_W          = 20;
localparam int WORD_W          = 32;
localparam int CL_W            = 128;  // Four words per line
localparam int BYTE_W          = 8;
localparam int BYTE_EN_W       = 4;
localparam int REG_ID_W        = 5;

localparam int LSB_BYTE_OFFSET = 0;
localparam int MSB_BYTE_OFFSET = 1;
localparam int LSB_WORD_OFFSET = 2;
localparam int MSB_WORD_OFFSET = 3;
localparam int LSB_CL_ADDR     = 4;
localparam int MSB_CL_ADDR     = 19;   // Top of the address

// ========================================
// Scalar types
// ========================================
typedef logic [ADDR_W-1:0]                  t_address;
typedef logic [WORD_W-1:0]                  t_word;
typedef logic [CL_W-1:0]                    t_cl_data;
typedef logic [MSB_CL_ADDR-LSB_CL_ADDR:0]   t_cl_address;
typedef logic [BYTE_EN_W-1:0]               t_byte_en;
typedef logic [REG_ID_W-1:0]                t_reg_id;

typedef enum logic {
    RD_OP = 1'b0,
    WR_OP = 1'b1
} t_opcode;

typedef enum logic [1:0] {
    NO_LU   = 2'd0,
    RD_LU   = 2'd1,
    WR_LU   = 2'd2,
    FILL_LU = 2'd3
} t_lu_op;

typedef enum logic [1:0] {
    NO_RESULT = 2'd0,
    HIT       = 2'd1,
    MISS      = 2'd2,
    FILL      = 2'd3
} t_lu_result;

// ========================================
// Request and response bundles
// ========================================
// Core to cache request
typedef struct packed {
    logic        valid;
    t_opcode     opcode;
    t_address    address;
    t_word       data;
    t_byte_en    byte_en;
    logic        sign_extend;
    t_reg_id     reg_id;
} t_req;

// Q1 lookup into the pipe
typedef struct packed {
    logic        valid;
    t_lu_op      lu_op;
    t_address    address;
    t_word       data;
    t_byte_en    byte_en;
    logic        sign_extend;
    t_reg_id     reg_id;
    logic        rd_indication;
    logic        wr_indication;
} t_lu_req;

// Q2 early indications from the pipe
typedef struct packed {
    logic        rd_miss;      // Cancels the Q1 lookup
    logic        fill_done;    // A line was written by a fill
    t_cl_address cl_address;
} t_early_lu_rsp;

// Q3 lookup result with the whole line
typedef struct packed {
    logic        valid;
    t_lu_op      lu_op;
    t_lu_result  lu_result;
    logic        rd_indication;
    t_address    address;
    t_cl_data    cl_data;
    t_byte_en    byte_en;
    logic        sign_extend;
    t_reg_id     reg_id;
} t_lu_rsp;

// Load data back to the core
typedef struct packed {
    logic        valid;
    t_address    address;
    t_word       data;
    t_reg_id     reg_id;
} t_rd_rsp;

endpackage

`default_nettype wire

// File: verilog/dcache_tq_top.sv
/*
 * Data cache TQ front end top
 * Aligner, miss reissue control and load formatter
 */
`timescale 1ns/100ps
`default_nettype none

module dcache_tq_top
    import dcache_tq_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // Core side
    input  var t_req          pre_core2cache_req,
    output logic              ready,
    output t_rd_rsp           cache2core_rsp,
    // Pipe side
    output t_lu_req           pipe_lu_req_q1,
    input  var t_early_lu_rsp pipe_early_lu_rsp_q2,
    input  var t_lu_rsp       pipe_lu_rsp_q3
);

t_req aligned_req;   // Store data on its byte lanes

// ========================================
// Request path
// ========================================
core_req_align u_core_req_align (
    .pre_core2cache_req (pre_core2cache_req),
    .aligned_req        (aligned_req)
);

miss_reissue_ctrl u_miss_reissue_ctrl (
    .clk                  (clk),
    .rst                  (rst),
    .aligned_req          (aligned_req),
    .pipe_early_lu_rsp_q2 (pipe_early_lu_rsp_q2),
    .pipe_lu_req_q1       (pipe_lu_req_q1),
    .ready                (ready)
);

// ========================================
// Response path
// ========================================
load_rsp_format u_load_rsp_format (
    .pipe_lu_rsp_q3 (pipe_lu_rsp_q3),
    .cache2core_rsp (cache2core_rsp)
);

endmodule

`default_nettype wire

// File: verilog/load_rsp_format.sv
/*
 * Load response formatter
 * Read hit and read fill detect on Q3
 * Word select, byte shift, byte enable mask and sign extension
 */
`timescale 1ns/100ps
`default_nettype none

module load_rsp_format
    import dcache_tq_pkg::*;
(
    input  var t_lu_rsp pipe_lu_rsp_q3,    // Q3 pipe result
    output t_rd_rsp     cache2core_rsp     // Load data to the core
);

logic rd_hit_pipe_rsp_q3;
logic fill_with_rd_indication_q3;

logic [MSB_WORD_OFFSET:LSB_WORD_OFFSET] word_offset;
logic [MSB_BYTE_OFFSET:LSB_BYTE_OFFSET] byte_offset;

t_word sel_word;        // Word picked from the line
t_word shifted_word;    // Addressed byte moved to bit 0
t_word masked_word;
logic  fill_bit;        // Top bit of the byte below

// ========================================
// Response detect
// ========================================
// Plain read hit
assign rd_hit_pipe_rsp_q3 = pipe_lu_rsp_q3.valid             &&
                            (pipe_lu_rsp_q3.lu_op == RD_LU)  &&
                            (pipe_lu_rsp_q3.lu_result == HIT);

// Fill that also serves a missed read
assign fill_with_rd_indication_q3 = pipe_lu_rsp_q3.valid               &&
                                    (pipe_lu_rsp_q3.lu_op == FILL_LU)  &&
                                    pipe_lu_rsp_q3.rd_indication;

// ========================================
// Data path
// ========================================
assign word_offset  = pipe_lu_rsp_q3.address[MSB_WORD_OFFSET:LSB_WORD_OFFSET];
assign byte_offset  = pipe_lu_rsp_q3.address[MSB_BYTE_OFFSET:LSB_BYTE_OFFSET];
assign sel_word     = pipe_lu_rsp_q3.cl_data[word_offset*WORD_W +: WORD_W];
assign shifted_word = sel_word >> {byte_offset, 3'b000};   // Zero fill from the top

// Disabled bytes are zero or copies of the sign bit just below
always_comb begin
    masked_word = '0;
    fill_bit    = 1'b0;     // Byte 0 has nothing below it
    for (int i = 0; i < BYTE_EN_W; i++) begin
        if (pipe_lu_rsp_q3.byte_en[i]) begin
            masked_word[i*BYTE_W +: BYTE_W] = shifted_word[i*BYTE_W +: BYTE_W];
        end else if (pipe_lu_rsp_q3.sign_extend) begin
            masked_word[i*BYTE_W +: BYTE_W] = {BYTE_W{fill_bit}};
        end
        fill_bit = masked_word[i*BYTE_W + BYTE_W - 1];
    end
end

assign cache2core_rsp.valid   = rd_hit_pipe_rsp_q3 || fill_with_rd_indication_q3;
assign cache2core_rsp.address = pipe_lu_rsp_q3.address;
assign cache2core_rsp.data    = masked_word;
assign cache2core_rsp.reg_id  = pipe_lu_rsp_q3.reg_id;

// Pipe never returns a live Q3 result without a lookup op
a_q3_has_lu_op: assert final (
    !pipe_lu_rsp_q3.valid || (pipe_lu_rsp_q3.lu_op != NO_LU)
) else $error("load_rsp_format: valid Q3 response with NO_LU, addr=%h",
              pipe_lu_rsp_q3.address);

endmodule

`default_nettype wire

// File: verilog/miss_reissue_ctrl.sv
/*
 * Read miss reissue control
 * Reissue buffer, sticky miss stall and fill match
 * Q1 lookup mux and core ready
 */
`timescale 1ns/100ps
`default_nettype none

module miss_reissue_ctrl
    import dcache_tq_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  var t_req          aligned_req,            // Aligned core request
    input  var t_early_lu_rsp pipe_early_lu_rsp_q2,   // Q2 miss and fill indications
    output t_lu_req           pipe_lu_req_q1,         // Lookup into the pipe
    output logic              ready                   // Core may send a request
);

t_req        core2cache_req;        // Core request or the reissued one
t_req        reissue_req;           // Request cancelled by the last miss
t_cl_address rd_miss_cl_address;    // Line the stall waits on

logic cancel_core_req;
logic stall_rd_miss_q;              // Sticky from miss until reissue
logic set_rd_miss_was_filled;
logic rd_miss_was_filled;
logic sel_reissue;

// ========================================
// Reissue buffer
// ========================================
// A Q2 read miss kills the request sitting in Q1 this cycle
assign cancel_core_req = pipe_early_lu_rsp_q2.rd_miss;

// Keep the killed request and the missing line until the fill comes back
always_ff @(posedge clk) begin
    if (cancel_core_req) begin
        reissue_req        <= core2cache_req;
        rd_miss_cl_address <= pipe_early_lu_rsp_q2.cl_address;
    end
end

// Only the line address tells the fill apart
assign set_rd_miss_was_filled = stall_rd_miss_q                                    &&
                                !rd_miss_was_filled                                &&
                                pipe_early_lu_rsp_q2.fill_done                     &&
                                (pipe_early_lu_rsp_q2.cl_address == rd_miss_cl_address);

assign sel_reissue = rd_miss_was_filled;   // One cycle after the matching fill

// ========================================
// Stall and filled flags
// ========================================
always_ff @(posedge clk) begin
    if (rst) begin
        stall_rd_miss_q    <= 1'b0;
        rd_miss_was_filled <= 1'b0;
    end else begin
        // A new miss wins over the reissue release
        if (cancel_core_req) begin
            stall_rd_miss_q <= 1'b1;
        end else if (sel_reissue) begin
            stall_rd_miss_q <= 1'b0;
        end
        if (sel_reissue) begin
            rd_miss_was_filled <= 1'b0;    // Single shot
        end else if (set_rd_miss_was_filled) begin
            rd_miss_was_filled <= 1'b1;
        end
    end
end

assign ready = !(stall_rd_miss_q || cancel_core_req);  // Low from the miss cycle on

// ========================================
// Q1 lookup mux
// ========================================
assign core2cache_req = sel_reissue ? reissue_req : aligned_req;

always_comb begin
    pipe_lu_req_q1 = '0;
    if (core2cache_req.valid && !cancel_core_req) begin
        pipe_lu_req_q1.valid         = 1'b1;
        pipe_lu_req_q1.lu_op         = (core2cache_req.opcode == WR_OP) ? WR_LU : RD_LU;
        pipe_lu_req_q1.address       = core2cache_req.address;
        pipe_lu_req_q1.data          = core2cache_req.data;
        pipe_lu_req_q1.byte_en       = core2cache_req.byte_en;
        pipe_lu_req_q1.sign_extend   = core2cache_req.sign_extend;
        pipe_lu_req_q1.reg_id        = core2cache_req.reg_id;
        pipe_lu_req_q1.rd_indication = (core2cache_req.opcode == RD_OP);
        pipe_lu_req_q1.wr_indication = (core2cache_req.opcode == WR_OP);
    end
end

// ========================================
// Checks
// ========================================
// Core honours ready while the miss is outstanding
a_no_core_req_in_stall: assert property (@(posedge clk) disable iff (rst)
    stall_rd_miss_q |-> !aligned_req.valid
) else $error("miss_reissue_ctrl: core valid while stalled, addr=%h", aligned_req.address);

// Reissue sends a held read back out, only during the stall
a_reissue_in_stall: assert property (@(posedge clk) disable iff (rst)
    sel_reissue |-> (stall_rd_miss_q && reissue_req.valid && (reissue_req.opcode == RD_OP))
) else $error("miss_reissue_ctrl: bad reissue, line=%h valid=%h",
              rd_miss_cl_address, reissue_req.valid);

endmodule

`default_nettype wire
